/* flist.f */
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/pipe_stage_reg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/execute_unit.sv
hdl/mem_access.sv
hdl/mips_core.sv
tb/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - hdl/isa_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/pipe_stage_reg.sv
      - hdl/fetch_unit.sv
      - hdl/decode_unit.sv
      - hdl/reg_file.sv
      - hdl/hazard_unit.sv
      - hdl/execute_unit.sv
      - hdl/mem_access.sv
      - hdl/mips_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_mips_core.sv

/* include/tb_iss.svh */
// reference instruction-set model and directed test programs for the core testbench
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// r-type word, shifts take their operand from rt
function automatic isa_pkg::word_t rtype_word(input logic [5:0] funct, input int rd,
	input int rs, input int rt, input int shamt);
	return {6'h00, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
endfunction

// immediate word, also used for loads, stores and branches
function automatic isa_pkg::word_t itype_word(input logic [5:0] op, input int rt,
	input int rs, input int imm);
	return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

// jump to a byte address in the same 256 MB region
function automatic isa_pkg::word_t jump_word(input int target);
	return {isa_pkg::OP_J, target[27:2]};
endfunction

task automatic emit_word(input isa_pkg::word_t w);
	prog[fill] = w;
	fill++;
endtask

// fills prog with one test program, id 0 leaves only the closing jump
task automatic build_program(input int id);
	for (int i = 0; i < IMEM_WORDS; i++)
		prog[i] = '0;
	fill = 0;
	case (id)
		1:
		begin
			// r20 is the store base, each result is stored right after it is made
			emit_word(itype_word(isa_pkg::OP_ADDI, 20, 0, 32'h100));
			emit_word(itype_word(isa_pkg::OP_ADDI, 1, 0, 16'h1234));
			emit_word(itype_word(isa_pkg::OP_ADDI, 2, 1, -5));
			// r1 comes from write-back, r2 from the memory stage
			emit_word(rtype_word(isa_pkg::F_ADD, 3, 1, 2, 0));
			emit_word(rtype_word(isa_pkg::F_SUB, 4, 3, 1, 0));
			emit_word(itype_word(isa_pkg::OP_SW, 3, 20, 0));
			emit_word(rtype_word(isa_pkg::F_AND, 5, 4, 3, 0));
			emit_word(rtype_word(isa_pkg::F_OR, 6, 5, 1, 0));
			emit_word(rtype_word(isa_pkg::F_NOR, 7, 6, 0, 0));
			emit_word(itype_word(isa_pkg::OP_SW, 4, 20, 4));
			emit_word(itype_word(isa_pkg::OP_SW, 7, 20, 8));
			emit_word(rtype_word(isa_pkg::F_SLT, 8, 7, 1, 0));
			emit_word(rtype_word(isa_pkg::F_SLL, 9, 0, 3, 4));
			emit_word(rtype_word(isa_pkg::F_SRL, 10, 0, 7, 8));
			emit_word(rtype_word(isa_pkg::F_SRA, 11, 0, 7, 8));
			emit_word(itype_word(isa_pkg::OP_SW, 8, 20, 12));
			emit_word(itype_word(isa_pkg::OP_SW, 9, 20, 16));
			emit_word(itype_word(isa_pkg::OP_SW, 10, 20, 20));
			emit_word(itype_word(isa_pkg::OP_SW, 11, 20, 24));
			emit_word(itype_word(isa_pkg::OP_LUI, 12, 0, 16'hbeef));
			emit_word(itype_word(isa_pkg::OP_ORI, 12, 12, 16'h8001));
			emit_word(itype_word(isa_pkg::OP_ANDI, 13, 12, 16'hff0f));
			emit_word(itype_word(isa_pkg::OP_SLTI, 14, 7, -3));
			emit_word(itype_word(isa_pkg::OP_SW, 12, 20, 28));
			emit_word(itype_word(isa_pkg::OP_SW, 13, 20, 32));
			emit_word(itype_word(isa_pkg::OP_SW, 14, 20, 36));
		end
		2:
		begin
			// each load is used by the very next instruction
			emit_word(itype_word(isa_pkg::OP_LW, 1, 0, 32'h40));
			emit_word(rtype_word(isa_pkg::F_ADD, 2, 1, 1, 0));
			emit_word(itype_word(isa_pkg::OP_SW, 2, 0, 32'h200));
			emit_word(itype_word(isa_pkg::OP_LW, 3, 0, 32'h44));
			emit_word(itype_word(isa_pkg::OP_SW, 3, 0, 32'h204));
			emit_word(itype_word(isa_pkg::OP_LW, 4, 0, 32'h48));
			emit_word(itype_word(isa_pkg::OP_ADDI, 5, 4, 7));
			emit_word(itype_word(isa_pkg::OP_SW, 5, 0, 32'h208));
		end
		3:
		begin
			emit_word(itype_word(isa_pkg::OP_ADDI, 1, 0, 5));
			emit_word(itype_word(isa_pkg::OP_ADDI, 2, 0, 5));
			emit_word(itype_word(isa_pkg::OP_ADDI, 3, 0, 9));
			// taken beq over two stores
			emit_word(itype_word(isa_pkg::OP_BEQ, 2, 1, 2));
			emit_word(itype_word(isa_pkg::OP_SW, 1, 0, 32'h300));
			emit_word(itype_word(isa_pkg::OP_SW, 2, 0, 32'h304));
			emit_word(itype_word(isa_pkg::OP_SW, 3, 0, 32'h308));
			// bne falls through
			emit_word(itype_word(isa_pkg::OP_BNE, 2, 1, 1));
			emit_word(itype_word(isa_pkg::OP_SW, 1, 0, 32'h30c));
			// bne taken over one store
			emit_word(itype_word(isa_pkg::OP_BNE, 3, 1, 1));
			emit_word(itype_word(isa_pkg::OP_SW, 3, 0, 32'h310));
			// beq falls through
			emit_word(itype_word(isa_pkg::OP_BEQ, 3, 1, 1));
			emit_word(itype_word(isa_pkg::OP_SW, 2, 0, 32'h314));
		end
		4:
		begin
			emit_word(itype_word(isa_pkg::OP_ADDI, 1, 0, 32'h77));
			emit_word(itype_word(isa_pkg::OP_SW, 1, 0, 32'h400));
			// jump from 0x08 to 0x14 over two stores
			emit_word(jump_word(32'h14));
			emit_word(itype_word(isa_pkg::OP_SW, 1, 0, 32'h404));
			emit_word(itype_word(isa_pkg::OP_SW, 1, 0, 32'h408));
			emit_word(itype_word(isa_pkg::OP_ADDI, 2, 1, 1));
			emit_word(itype_word(isa_pkg::OP_SW, 2, 0, 32'h40c));
		end
		5:
		begin
			emit_word(itype_word(isa_pkg::OP_LW, 1, 0, 32'h20));
			emit_word(itype_word(isa_pkg::OP_LW, 2, 0, 32'h24));
			emit_word(rtype_word(isa_pkg::F_ADD, 3, 1, 2, 0));
			// back to back memory accesses keep stb high
			emit_word(itype_word(isa_pkg::OP_SW, 3, 0, 32'h500));
			emit_word(itype_word(isa_pkg::OP_SW, 1, 0, 32'h504));
			emit_word(itype_word(isa_pkg::OP_LW, 4, 0, 32'h500));
			emit_word(rtype_word(isa_pkg::F_SUB, 5, 4, 2, 0));
			emit_word(itype_word(isa_pkg::OP_SW, 5, 0, 32'h508));
			emit_word(itype_word(isa_pkg::OP_ADDI, 6, 0, 32'h510));
			emit_word(itype_word(isa_pkg::OP_SW, 5, 6, 4));
			emit_word(itype_word(isa_pkg::OP_LW, 7, 6, 4));
			emit_word(itype_word(isa_pkg::OP_BNE, 5, 7, 1));
			emit_word(itype_word(isa_pkg::OP_SW, 7, 0, 32'h518));
			emit_word(itype_word(isa_pkg::OP_BEQ, 5, 7, 1));
			emit_word(itype_word(isa_pkg::OP_SW, 0, 0, 32'h51c));
			emit_word(itype_word(isa_pkg::OP_SW, 4, 0, 32'h520));
		end
		default:
		begin
		end
	endcase
	// every program ends in a jump to itself
	emit_word(jump_word(fill * 4));
endtask

// runs prog over ref_mem without delay slots, fills the expected store list
// and returns how many instructions ran up to the closing self jump
function automatic int run_reference();
	isa_pkg::word_t r [32];
	isa_pkg::word_t pc;
	isa_pkg::word_t ins;
	isa_pkg::word_t a;
	isa_pkg::word_t b;
	isa_pkg::word_t imm_s;
	isa_pkg::word_t imm_z;
	isa_pkg::word_t res;
	isa_pkg::word_t nxt;
	isa_pkg::word_t addr;
	logic [4:0] dst;
	logic wr;
	logic done;
	int count;

	for (int i = 0; i < 32; i++)
		r[i] = '0;
	exp_adr.delete();
	exp_dat.delete();
	pc = '0;
	count = 0;
	done = 1'b0;
	while (!done && count < 4096)
	begin
		ins = prog[pc[7:2]];
		count++;
		a = r[ins[25:21]];
		b = r[ins[20:16]];
		imm_s = {{16{ins[15]}}, ins[15:0]};
		imm_z = {16'h0000, ins[15:0]};
		addr = a + imm_s;
		nxt = pc + 32'd4;
		res = '0;
		wr = 1'b0;
		dst = ins[20:16];
		case (ins[31:26])
			isa_pkg::OP_RTYPE:
			begin
				wr = 1'b1;
				dst = ins[15:11];
				case (ins[5:0])
					isa_pkg::F_ADD: res = a + b;
					isa_pkg::F_SUB: res = a - b;
					isa_pkg::F_AND: res = a & b;
					isa_pkg::F_OR:  res = a | b;
					isa_pkg::F_NOR: res = ~(a | b);
					isa_pkg::F_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					isa_pkg::F_SLL: res = b << ins[10:6];
					isa_pkg::F_SRL: res = b >> ins[10:6];
					isa_pkg::F_SRA: res = $signed(b) >>> ins[10:6];
					default:        wr = 1'b0;
				endcase
			end
			isa_pkg::OP_ADDI:
			begin
				res = a + imm_s;
				wr = 1'b1;
			end
			isa_pkg::OP_SLTI:
			begin
				res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
				wr = 1'b1;
			end
			isa_pkg::OP_ANDI:
			begin
				res = a & imm_z;
				wr = 1'b1;
			end
			isa_pkg::OP_ORI:
			begin
				res = a | imm_z;
				wr = 1'b1;
			end
			isa_pkg::OP_LUI:
			begin
				res = {ins[15:0], 16'h0000};
				wr = 1'b1;
			end
			isa_pkg::OP_LW:
			begin
				res = ref_mem[addr[10:2]];
				wr = 1'b1;
			end
			isa_pkg::OP_SW:
			begin
				ref_mem[addr[10:2]] = b;
				exp_adr.push_back(addr);
				exp_dat.push_back(b);
			end
			isa_pkg::OP_BEQ:
			begin
				if (a == b)
					nxt = pc + 32'd4 + (imm_s << 2);
			end
			isa_pkg::OP_BNE:
			begin
				if (a != b)
					nxt = pc + 32'd4 + (imm_s << 2);
			end
			isa_pkg::OP_J:
			begin
				nxt = {nxt[31:28], ins[25:0], 2'b00};
				// a jump to itself ends the program
				if (nxt == pc)
					done = 1'b1;
			end
			default:
			begin
			end
		endcase
		if (wr && dst != 5'd0)
			r[dst] = res;
		pc = nxt;
	end
	return count;
endfunction

`endif

/* tb/tb_mips_core.sv */
// testbench for the pipelined core, runs directed programs and checks the store stream
`timescale 1ns/1ps

module tb_mips_core;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 512;
	// quiet cycles after the last expected store
	localparam int IDLE_CYCLES = 20;

	logic clk;
	logic rst_n;
	isa_pkg::word_t imem_addr;
	isa_pkg::word_t imem_data;
	pipe_pkg::wb_req_t wb_req;
	pipe_pkg::wb_rsp_t wb_rsp;

	// program image, data memory and the reference copy of it
	isa_pkg::word_t prog [IMEM_WORDS];
	isa_pkg::word_t dmem [DMEM_WORDS];
	isa_pkg::word_t ref_mem [DMEM_WORDS];
	int fill;

	// expected and acknowledged store lists
	isa_pkg::word_t exp_adr [$];
	isa_pkg::word_t exp_dat [$];
	isa_pkg::word_t seen_adr [$];
	isa_pkg::word_t seen_dat [$];
	int stores_seen;
	int test_errors;
	int total_errors;
	int tests_passed;
	int tests_failed;

	// slave side of the current transfer
	logic in_transfer;
	int wait_left;
	pipe_pkg::wb_req_t held_req;

	`include "tb_iss.svh"

	mips_core #(
		.RESET_PC (32'h0000_0000)
	) uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp)
	);

	// instruction memory answers in the same cycle
	assign imem_data = prog[imem_addr[7:2]];

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// pattern mixes every address bit
	function automatic isa_pkg::word_t fill_word(input isa_pkg::word_t addr);
		return (addr * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
	endfunction

	// request must not move while the slave is still waiting
	task automatic check_steady_request();
		if (wb_req.adr !== held_req.adr)
		begin
			$display("CHECK FAILED wb_req.adr in wait cycle expected %h got %h",
				held_req.adr, wb_req.adr);
			test_errors++;
		end
		if (wb_req.we !== held_req.we)
		begin
			$display("CHECK FAILED wb_req.we in wait cycle expected %h got %h",
				held_req.we, wb_req.we);
			test_errors++;
		end
		if (wb_req.dat_w !== held_req.dat_w)
		begin
			$display("CHECK FAILED wb_req.dat_w in wait cycle expected %h got %h",
				held_req.dat_w, wb_req.dat_w);
			test_errors++;
		end
	endtask

	// data memory slave with 0 to 3 wait cycles before a one-cycle ack
	initial
	begin
		// wait-state sequence starts from one fixed seed
		void'($urandom(83));
		forever
		begin
			@(negedge clk);
			if (!rst_n)
			begin
				wb_rsp = '0;
				in_transfer = 1'b0;
				wait_left = 0;
			end
			else
			begin
				// cycle after an ack starts fresh so a high stb means a new request
				if (wb_rsp.ack)
					in_transfer = 1'b0;
				wb_rsp = '0;
				if (wb_req.cyc && wb_req.stb)
				begin
					// only full words exist on this bus
					if (wb_req.sel !== '1)
					begin
						$display("CHECK FAILED wb_req.sel expected %h got %h",
							{pipe_pkg::SEL_W{1'b1}}, wb_req.sel);
						test_errors++;
					end
					if (!in_transfer)
					begin
						in_transfer = 1'b1;
						wait_left = $urandom % 4;
						held_req = wb_req;
					end
					else
						check_steady_request();
					if (wait_left == 0)
					begin
						wb_rsp.ack = 1'b1;
						if (wb_req.we)
						begin
							dmem[wb_req.adr[10:2]] = wb_req.dat_w;
							seen_adr.push_back(wb_req.adr);
							seen_dat.push_back(wb_req.dat_w);
						end
						else
							wb_rsp.dat_r = dmem[wb_req.adr[10:2]];
					end
					else
						wait_left--;
				end
				else
					in_transfer = 1'b0;
			end
		end
	end

	task automatic compare_store(input isa_pkg::word_t adr, input isa_pkg::word_t dat);
		if (stores_seen >= exp_adr.size())
		begin
			$display("unexpected store to %h with data %h after the last expected store",
				adr, dat);
			test_errors++;
		end
		else
		begin
			if (adr !== exp_adr[stores_seen])
			begin
				$display("CHECK FAILED wb_req.adr store %0d expected %h got %h",
					stores_seen, exp_adr[stores_seen], adr);
				test_errors++;
			end
			if (dat !== exp_dat[stores_seen])
			begin
				$display("CHECK FAILED wb_req.dat_w store %0d expected %h got %h",
					stores_seen, exp_dat[stores_seen], dat);
				test_errors++;
			end
		end
		stores_seen++;
	endtask

	// stores acked at the falling edge are compared at the next rising edge
	always @(posedge clk)
	begin
		if (seen_adr.size() > 0)
			compare_store(seen_adr.pop_front(), seen_dat.pop_front());
	end

	task automatic run_test(input int id, input string name);
		int count;
		int limit;
		int cycles;
		int idle;

		@(negedge clk);
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		build_program(id);
		for (int i = 0; i < DMEM_WORDS; i++)
		begin
			dmem[i] = fill_word(i * 4);
			ref_mem[i] = dmem[i];
		end
		count = run_reference();
		seen_adr.delete();
		seen_dat.delete();
		stores_seen = 0;
		test_errors = 0;
		rst_n = 1'b1;
		// bus must be idle out of reset
		if (wb_req.cyc !== 1'b0)
		begin
			$display("CHECK FAILED wb_req.cyc after reset expected 0 got %h", wb_req.cyc);
			test_errors++;
		end
		if (wb_req.stb !== 1'b0)
		begin
			$display("CHECK FAILED wb_req.stb after reset expected 0 got %h", wb_req.stb);
			test_errors++;
		end
		if (wb_req.we !== 1'b0)
		begin
			$display("CHECK FAILED wb_req.we after reset expected 0 got %h", wb_req.we);
			test_errors++;
		end
		// worst case about eight cycles per instruction with wait states
		limit = 8 * count + 50;
		cycles = 0;
		idle = 0;
		while (cycles < limit && (stores_seen < exp_adr.size() || idle < IDLE_CYCLES))
		begin
			@(negedge clk);
			cycles++;
			if (stores_seen >= exp_adr.size())
				idle++;
		end
		if (stores_seen < exp_adr.size())
		begin
			$display("test %0d timed out after %0d cycles with %0d of %0d stores seen",
				id, cycles, stores_seen, exp_adr.size());
			test_errors++;
		end
		total_errors += test_errors;
		if (test_errors == 0)
		begin
			tests_passed++;
			$display("test %0d %s passed, %0d stores in %0d cycles", id, name,
				stores_seen, cycles);
		end
		else
		begin
			tests_failed++;
			$display("test %0d %s failed with %0d errors", id, name, test_errors);
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		wb_rsp = '0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		stores_seen = 0;
		test_errors = 0;
		build_program(0);

		run_test(1, "alu chain");
		run_test(2, "load use");
		run_test(3, "branches");
		run_test(4, "jump");
		run_test(5, "mixed memory");

		$display("tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, total_errors);
		if (tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* hdl/mips_core.sv */
// five-stage mips32 subset core with combinational instruction port and wishbone data port
`timescale 1ns/1ps

module mips_core #(
	parameter isa_pkg::word_t RESET_PC = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	output isa_pkg::word_t    imem_addr,
	input  isa_pkg::word_t    imem_data,
	output pipe_pkg::wb_req_t wb_req,
	input  pipe_pkg::wb_rsp_t wb_rsp
);

	pipe_pkg::if_id_t if_id_d;
	pipe_pkg::if_id_t if_id_q;
	pipe_pkg::id_ex_t id_ex_d;
	pipe_pkg::id_ex_t id_ex_q;
	pipe_pkg::ex_mem_t ex_mem_d;
	pipe_pkg::ex_mem_t ex_mem_q;
	pipe_pkg::mem_wb_t mem_wb_d;
	pipe_pkg::mem_wb_t mem_wb_q;

	isa_pkg::word_t rs_data;
	isa_pkg::word_t rt_data;
	isa_pkg::word_t jump_target;
	isa_pkg::word_t branch_target;
	pipe_pkg::fwd_sel_e fwd_a;
	pipe_pkg::fwd_sel_e fwd_b;
	logic jump_taken;
	logic branch_taken;
	logic load_stall;
	logic branch_flush;
	logic mem_busy;

	// bus wait freezes all, load-use freezes only the front end
	wire front_hold = mem_busy || load_stall;
	wire if_id_bubble = branch_flush || jump_taken;
	wire id_ex_bubble = branch_flush || load_stall;

	// instruction arrives in the same cycle as its address
	assign if_id_d = '{instr: imem_data, pc: imem_addr};

	fetch_unit #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk           (clk),
		.rst_n         (rst_n),
		.hold          (front_hold),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.jump_taken    (jump_taken),
		.jump_target   (jump_target),
		.pc            (imem_addr)
	);

	pipe_stage_reg #(.payload_t(pipe_pkg::if_id_t)) u_if_id (
		.clk (clk), .rst_n (rst_n), .hold (front_hold), .bubble (if_id_bubble),
		.d (if_id_d), .q (if_id_q)
	);

	reg_file u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_idx  (if_id_q.instr.rs),
		.rt_idx  (if_id_q.instr.rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb      (mem_wb_q)
	);

	decode_unit u_decode (
		.if_id       (if_id_q),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.id_ex       (id_ex_d),
		.jump_taken  (jump_taken),
		.jump_target (jump_target)
	);

	hazard_unit u_hazard (
		.if_id        (if_id_q),
		.id_ex        (id_ex_q),
		.ex_mem       (ex_mem_q),
		.mem_wb       (mem_wb_q),
		.branch_taken (branch_taken),
		.load_stall   (load_stall),
		.branch_flush (branch_flush),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b)
	);

	pipe_stage_reg #(.payload_t(pipe_pkg::id_ex_t)) u_id_ex (
		.clk (clk), .rst_n (rst_n), .hold (mem_busy), .bubble (id_ex_bubble),
		.d (id_ex_d), .q (id_ex_q)
	);

	// memory stage forwards its alu result, write-back its final data
	execute_unit u_execute (
		.id_ex         (id_ex_q),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.mem_fwd       (ex_mem_q.alu_result),
		.wb_fwd        (mem_wb_q.wb_data),
		.ex_mem        (ex_mem_d),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	pipe_stage_reg #(.payload_t(pipe_pkg::ex_mem_t)) u_ex_mem (
		.clk (clk), .rst_n (rst_n), .hold (mem_busy), .bubble (1'b0),
		.d (ex_mem_d), .q (ex_mem_q)
	);

	mem_access u_mem (
		.ex_mem   (ex_mem_q),
		.wb_rsp   (wb_rsp),
		.wb_req   (wb_req),
		.mem_busy (mem_busy),
		.mem_wb   (mem_wb_d)
	);

	pipe_stage_reg #(.payload_t(pipe_pkg::mem_wb_t)) u_mem_wb (
		.clk (clk), .rst_n (rst_n), .hold (mem_busy), .bubble (1'b0),
		.d (mem_wb_d), .q (mem_wb_q)
	);

endmodule

/* hdl/mem_access.sv */
// memory stage acting as wishbone classic master and picking the write-back data
`timescale 1ns/1ps

module mem_access (
	input  pipe_pkg::ex_mem_t ex_mem,
	input  pipe_pkg::wb_rsp_t wb_rsp,
	output pipe_pkg::wb_req_t wb_req,
	output logic              mem_busy,
	output pipe_pkg::mem_wb_t mem_wb
);

	logic access;

	assign access = ex_mem.mem_read || ex_mem.mem_write;

	// ex/mem is frozen until ack, so the request stays steady by itself
	always_comb
	begin
		wb_req.cyc = access;
		wb_req.stb = access;
		wb_req.we = ex_mem.mem_write;
		wb_req.adr = ex_mem.alu_result;
		wb_req.dat_w = ex_mem.store_data;
		// full words only
		wb_req.sel = '1;
	end

	// pipeline freezes until the slave acknowledges
	assign mem_busy = access && !wb_rsp.ack;

	// load data is only valid in the ack cycle, which is when mem/wb loads
	always_comb
	begin
		mem_wb.reg_write = ex_mem.reg_write;
		mem_wb.dest = ex_mem.dest;
		mem_wb.wb_data = ex_mem.mem_to_reg ? wb_rsp.dat_r : ex_mem.alu_result;
	end

endmodule

/* hdl/execute_unit.sv */
// execute stage with operand forwarding, alu, branch resolution and destination choice
`timescale 1ns/1ps

module execute_unit (
	input  pipe_pkg::id_ex_t   id_ex,
	input  pipe_pkg::fwd_sel_e fwd_a,
	input  pipe_pkg::fwd_sel_e fwd_b,
	input  isa_pkg::word_t     mem_fwd,
	input  isa_pkg::word_t     wb_fwd,
	output pipe_pkg::ex_mem_t  ex_mem,
	output logic               branch_taken,
	output isa_pkg::word_t     branch_target
);

	isa_pkg::word_t op_a;
	isa_pkg::word_t op_rt;
	isa_pkg::word_t op_b;
	isa_pkg::word_t alu_y;

	// first operand, always rs
	always_comb
	begin
		case (fwd_a)
			pipe_pkg::FWD_MEM: op_a = mem_fwd;
			pipe_pkg::FWD_WB:  op_a = wb_fwd;
			default:           op_a = id_ex.rs_data;
		endcase
	end

	// rt value, also the store data
	always_comb
	begin
		case (fwd_b)
			pipe_pkg::FWD_MEM: op_rt = mem_fwd;
			pipe_pkg::FWD_WB:  op_rt = wb_fwd;
			default:           op_rt = id_ex.rt_data;
		endcase
	end

	assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : op_rt;

	// shifts act on rt by shamt
	always_comb
	begin
		case (id_ex.ctrl.alu_op)
			isa_pkg::ALU_AND: alu_y = op_a & op_b;
			isa_pkg::ALU_OR:  alu_y = op_a | op_b;
			isa_pkg::ALU_ADD: alu_y = op_a + op_b;
			isa_pkg::ALU_SUB: alu_y = op_a - op_b;
			isa_pkg::ALU_NOR: alu_y = ~(op_a | op_b);
			isa_pkg::ALU_SLT: alu_y = isa_pkg::word_t'($signed(op_a) < $signed(op_b));
			isa_pkg::ALU_SLL: alu_y = op_b << id_ex.shamt;
			isa_pkg::ALU_SRL: alu_y = op_b >> id_ex.shamt;
			isa_pkg::ALU_SRA: alu_y = $unsigned($signed(op_b) >>> id_ex.shamt);
			// immediate into the upper half
			isa_pkg::ALU_LUI: alu_y = {op_b[15:0], 16'h0000};
			default:          alu_y = '0;
		endcase
	end

	// beq and bne compare the two forwarded registers
	assign branch_taken = (id_ex.ctrl.branch_eq && (op_a == op_rt)) ||
		(id_ex.ctrl.branch_ne && (op_a != op_rt));
	// pc + 4 + word offset
	assign branch_target = id_ex.pc + isa_pkg::word_t'(4) + {id_ex.imm[29:0], 2'b00};

	always_comb
	begin
		ex_mem.reg_write = id_ex.ctrl.reg_write;
		ex_mem.mem_read = id_ex.ctrl.mem_read;
		ex_mem.mem_write = id_ex.ctrl.mem_write;
		ex_mem.mem_to_reg = id_ex.ctrl.mem_to_reg;
		ex_mem.alu_result = alu_y;
		ex_mem.store_data = op_rt;
		// r-type writes rd, immediates and loads write rt
		ex_mem.dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
	end

endmodule

/* hdl/hazard_unit.sv */
// hazard unit for load-use stall, taken-branch flush and operand forwarding selects
`timescale 1ns/1ps

module hazard_unit (
	input  pipe_pkg::if_id_t  if_id,
	input  pipe_pkg::id_ex_t  id_ex,
	input  pipe_pkg::ex_mem_t ex_mem,
	input  pipe_pkg::mem_wb_t mem_wb,
	input  logic              branch_taken,
	output logic              load_stall,
	output logic              branch_flush,
	output pipe_pkg::fwd_sel_e fwd_a,
	output pipe_pkg::fwd_sel_e fwd_b
);

	// load data only exists after the memory stage, so hold decode one cycle
	assign load_stall = id_ex.ctrl.mem_read &&
		((id_ex.rt == if_id.instr.rs) || (id_ex.rt == if_id.instr.rt));

	// both younger instructions came from the wrong path
	assign branch_flush = branch_taken;

	// memory stage holds the newer value, so it wins over write-back
	always_comb
	begin
		fwd_a = pipe_pkg::FWD_REG;
		if (ex_mem.reg_write && ex_mem.dest != '0 && ex_mem.dest == id_ex.rs)
			fwd_a = pipe_pkg::FWD_MEM;
		else if (mem_wb.reg_write && mem_wb.dest != '0 && mem_wb.dest == id_ex.rs)
			fwd_a = pipe_pkg::FWD_WB;

		fwd_b = pipe_pkg::FWD_REG;
		if (ex_mem.reg_write && ex_mem.dest != '0 && ex_mem.dest == id_ex.rt)
			fwd_b = pipe_pkg::FWD_MEM;
		else if (mem_wb.reg_write && mem_wb.dest != '0 && mem_wb.dest == id_ex.rt)
			fwd_b = pipe_pkg::FWD_WB;
	end

endmodule

/* hdl/reg_file.sv */
// register file of thirty-two words with write-through reads
`timescale 1ns/1ps

module reg_file (
	input  logic              clk,
	input  logic              rst_n,
	input  isa_pkg::reg_idx_t rs_idx,
	input  isa_pkg::reg_idx_t rt_idx,
	output isa_pkg::word_t    rs_data,
	output isa_pkg::word_t    rt_data,
	input  pipe_pkg::mem_wb_t wb
);

	isa_pkg::word_t regs [32];
	logic wr_en;

	// $zero is never written
	assign wr_en = wb.reg_write && (wb.dest != '0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[wb.dest] <= wb.wb_data;
	end

	// a read of the register written this cycle sees the new value
	assign rs_data = (rs_idx == '0) ? '0 : (wr_en && wb.dest == rs_idx) ? wb.wb_data : regs[rs_idx];
	assign rt_data = (rt_idx == '0) ? '0 : (wr_en && wb.dest == rt_idx) ? wb.wb_data : regs[rt_idx];

endmodule

/* hdl/decode_unit.sv */
// decode stage turning an instruction into control, operands, immediate and jump target
`timescale 1ns/1ps

module decode_unit (
	input  pipe_pkg::if_id_t if_id,
	input  isa_pkg::word_t   rs_data,
	input  isa_pkg::word_t   rt_data,
	output pipe_pkg::id_ex_t id_ex,
	output logic             jump_taken,
	output isa_pkg::word_t   jump_target
);

	pipe_pkg::ctrl_t ctrl;
	logic [isa_pkg::IMM_W-1:0] imm16;
	logic zero_ext;
	isa_pkg::word_t pc_plus4;

	// immediate lives in rd, shamt and funct
	assign imm16 = {if_id.instr.rd, if_id.instr.shamt, if_id.instr.funct};
	assign pc_plus4 = if_id.pc + isa_pkg::word_t'(4);
	// region of the next pc with the index shifted to a word address
	assign jump_target = {pc_plus4[31:28], if_id.instr[isa_pkg::JIDX_W-1:0], 2'b00};

	// one-level decode, alu op picked straight from opcode and funct
	always_comb
	begin
		ctrl = '0;
		zero_ext = 1'b0;
		jump_taken = 1'b0;
		case (if_id.instr.opcode)
			isa_pkg::OP_RTYPE:
			begin
				// all-zero word is a nop, keep it a bubble
				if (if_id.instr != '0)
				begin
					ctrl.reg_write = 1'b1;
					ctrl.reg_dst = 1'b1;
					case (if_id.instr.funct)
						isa_pkg::F_ADD: ctrl.alu_op = isa_pkg::ALU_ADD;
						isa_pkg::F_SUB: ctrl.alu_op = isa_pkg::ALU_SUB;
						isa_pkg::F_AND: ctrl.alu_op = isa_pkg::ALU_AND;
						isa_pkg::F_OR:  ctrl.alu_op = isa_pkg::ALU_OR;
						isa_pkg::F_NOR: ctrl.alu_op = isa_pkg::ALU_NOR;
						isa_pkg::F_SLT: ctrl.alu_op = isa_pkg::ALU_SLT;
						isa_pkg::F_SLL: ctrl.alu_op = isa_pkg::ALU_SLL;
						isa_pkg::F_SRL: ctrl.alu_op = isa_pkg::ALU_SRL;
						isa_pkg::F_SRA: ctrl.alu_op = isa_pkg::ALU_SRA;
						// unknown funct, drop the instruction
						default: ctrl = '0;
					endcase
				end
			end
			isa_pkg::OP_ADDI:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = isa_pkg::ALU_ADD;
			end
			isa_pkg::OP_SLTI:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = isa_pkg::ALU_SLT;
			end
			isa_pkg::OP_ANDI, isa_pkg::OP_ORI:
			begin
				// logical immediates are zero extended in mips32
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
				zero_ext = 1'b1;
				ctrl.alu_op = (if_id.instr.opcode == isa_pkg::OP_ANDI) ?
					isa_pkg::ALU_AND : isa_pkg::ALU_OR;
			end
			isa_pkg::OP_LUI:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = isa_pkg::ALU_LUI;
			end
			isa_pkg::OP_LW:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = isa_pkg::ALU_ADD;
			end
			isa_pkg::OP_SW:
			begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = isa_pkg::ALU_ADD;
			end
			// branches compare the two forwarded registers in execute
			isa_pkg::OP_BEQ: ctrl.branch_eq = 1'b1;
			isa_pkg::OP_BNE: ctrl.branch_ne = 1'b1;
			// jump leaves a bubble behind in id/ex
			isa_pkg::OP_J:   jump_taken = 1'b1;
			default:         ctrl = '0;
		endcase
	end

	always_comb
	begin
		id_ex.ctrl = ctrl;
		id_ex.pc = if_id.pc;
		id_ex.rs_data = rs_data;
		id_ex.rt_data = rt_data;
		id_ex.imm = zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
		id_ex.shamt = if_id.instr.shamt;
		id_ex.rs = if_id.instr.rs;
		id_ex.rt = if_id.instr.rt;
		id_ex.rd = if_id.instr.rd;
	end

endmodule

/* hdl/fetch_unit.sv */
// fetch stage holding the program counter and choosing the next fetch address
`timescale 1ns/1ps

module fetch_unit #(
	parameter isa_pkg::word_t RESET_PC = '0
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           hold,
	input  logic           branch_taken,
	input  isa_pkg::word_t branch_target,
	input  logic           jump_taken,
	input  isa_pkg::word_t jump_target,
	output isa_pkg::word_t pc
);

	isa_pkg::word_t next_pc;

	// branch sits in execute, jump in decode
	// so the branch is older and goes first
	always_comb
	begin
		if (branch_taken)
			next_pc = branch_target;
		else if (jump_taken)
			next_pc = jump_target;
		else
			next_pc = pc + isa_pkg::word_t'(4);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc <= RESET_PC;
		else if (!hold)
			pc <= next_pc;
	end

endmodule

/* hdl/pipe_stage_reg.sv */
// pipeline boundary register with hold and bubble insertion for any payload type
`timescale 1ns/1ps

module pipe_stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	// hold beats bubble, so a frozen stage keeps its instruction
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			q <= '0;
		else if (!hold)
			q <= bubble ? payload_t'('0) : d;
	end

endmodule

/* hdl/pipe_pkg.sv */
// pipeline package with the control bundle, stage payloads and wishbone bundles
package pipe_pkg;

	// byte lanes on the data bus
	localparam int SEL_W = isa_pkg::XLEN / 8;

	// all-zero bundle means bubble
	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic alu_src;
		logic reg_dst;
		logic branch_eq;
		logic branch_ne;
		isa_pkg::alu_op_e alu_op;
	} ctrl_t;

	// fetch to decode
	typedef struct packed {
		isa_pkg::instr_t instr;
		isa_pkg::word_t pc;
	} if_id_t;

	// decode to execute
	typedef struct packed {
		ctrl_t ctrl;
		isa_pkg::word_t pc;
		isa_pkg::word_t rs_data;
		isa_pkg::word_t rt_data;
		isa_pkg::word_t imm;
		logic [4:0] shamt;
		isa_pkg::reg_idx_t rs;
		isa_pkg::reg_idx_t rt;
		isa_pkg::reg_idx_t rd;
	} id_ex_t;

	// execute to memory
	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		isa_pkg::word_t alu_result;
		isa_pkg::word_t store_data;
		isa_pkg::reg_idx_t dest;
	} ex_mem_t;

	// memory to write-back
	typedef struct packed {
		logic reg_write;
		isa_pkg::reg_idx_t dest;
		isa_pkg::word_t wb_data;
	} mem_wb_t;

	// operand source in execute
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_WB  = 2'b01,
		FWD_MEM = 2'b10
	} fwd_sel_e;

	// wishbone classic master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		isa_pkg::word_t adr;
		isa_pkg::word_t dat_w;
		logic [SEL_W-1:0] sel;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		isa_pkg::word_t dat_r;
	} wb_rsp_t;

endpackage

/* hdl/isa_pkg.sv */
// isa package with the mips32 subset encodings, instruction fields and alu operation codes
package isa_pkg;

	// datapath and address width
	localparam int XLEN = 32;
	// register index width, 32 general registers
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W = 16;
	localparam int JIDX_W = 26;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_idx_t;

	// major opcodes of the kept instructions
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// function field of the kept r-type operations
	typedef enum logic [5:0] {
		F_SLL = 6'h00,
		F_SRL = 6'h02,
		F_SRA = 6'h03,
		F_ADD = 6'h20,
		F_SUB = 6'h22,
		F_AND = 6'h24,
		F_OR  = 6'h25,
		F_NOR = 6'h27,
		F_SLT = 6'h2a
	} funct_e;

	// alu operations, same codes the team uses in its alu
	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_OR  = 4'h1,
		ALU_ADD = 4'h2,
		ALU_SRL = 4'h3,
		ALU_SRA = 4'h4,
		ALU_SUB = 4'h6,
		ALU_SLT = 4'h7,
		ALU_LUI = 4'ha,
		ALU_NOR = 4'hc,
		ALU_SLL = 4'hd
	} alu_op_e;

	// r-type view of a word
	// immediate is {rd, shamt, funct}, jump index is everything below opcode
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t;

endpackage
